//--- include/periph_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral address map is a 16 KiB region split into 4 KiB windows.
// Offsets are compared against the low 12 address bits of each window.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

`define GPIO_WIDTH      8

`define PERIPH_BASE     32'h3000_0000
`define PERIPH_SIZE     32'h0000_4000
`define PERIPH_IDX_LSB  12

`define PLIC_IDX        0
`define GPIO_IDX        1
`define TIMER_IDX       2

// Interrupt source numbering, source 0 is reserved
`define PLIC_GPIO_SRC   1
`define PLIC_TIMER_SRC  9
`define PLIC_USED_NINT  11

`define REG_ERR_DATA    32'hBADC_AB1E

`define PLIC_PENDING_OFS  12'h000
`define PLIC_ENABLE_OFS   12'h004
`define PLIC_CLAIM_OFS    12'h008
`define PLIC_MSIP_OFS     12'h00C

`define GPIO_IN_OFS       12'h000
`define GPIO_OUT_OFS      12'h004
`define GPIO_OE_OFS       12'h008
`define GPIO_INTR_EN_OFS  12'h00C
`define GPIO_STATUS_OFS   12'h010

`define TIMER_MTIME_OFS   12'h000
`define TIMER_PRESC_OFS   12'h004
`define TIMER_CTRL_OFS    12'h008
`define TIMER_CMP0_OFS    12'h00C
`define TIMER_CMP1_OFS    12'h010

`endif

//--- rtl/bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OBI and register bus types, 32-bit address and data only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  typedef struct packed {
    logic  req;
    logic  we;
    strb_t be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    logic  err;
    data_t rdata;
  } obi_resp_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } reg_rsp_t;

  // Byte enables expanded to a bit mask
  function automatic data_t strb_mask(strb_t strb);
    data_t mask;
    for (int b = 0; b < $bits(strb_t); b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

  function automatic data_t masked_write(data_t old_val, data_t new_val, strb_t strb);
    data_t mask;
    mask = strb_mask(strb);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

endpackage

`default_nettype wire

//--- rtl/periph_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral vector types. Interrupt IDs cover at most 32 sources.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "periph_consts.svh"

package periph_pkg;

  // One bit per GPIO pin
  typedef logic [`GPIO_WIDTH-1:0] gpio_t;

  typedef logic [31:0] mtime_t;

  typedef logic [4:0] irq_id_t;

  // Window select from address bits 13:12
  typedef logic [1:0] periph_idx_t;

endpackage

`default_nettype wire

//--- rtl/obi_to_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Grants every request, no back-pressure. The response follows one cycle
// later, write responses carry zero data.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module obi_to_reg (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire bus_pkg::obi_req_t  obi_req_i,
  output bus_pkg::obi_resp_t      obi_resp_o,
  output bus_pkg::reg_req_t       reg_req_o,
  input  wire bus_pkg::reg_rsp_t  reg_rsp_i
);

  import bus_pkg::*;

  logic  rvalid_q;
  logic  err_q;
  data_t rdata_q;

  assign reg_req_o.valid = obi_req_i.req;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;
  assign reg_req_o.wstrb = obi_req_i.be;

  assign obi_resp_o.gnt    = obi_req_i.req;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.err    = err_q;
  assign obi_resp_o.rdata  = rdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
      err_q    <= obi_req_i.req & reg_rsp_i.error;
    end
  end

  // Only meaningful alongside rvalid
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= obi_req_i.we ? '0 : reg_rsp_i.rdata;
    end
  end

endmodule

`default_nettype wire

//--- rtl/reg_demux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational window decode on address bits 13:12. Windows above the
// timer answer with an error and the fixed error pattern.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module reg_demux (
  input  wire bus_pkg::reg_req_t                  in_req_i,
  output bus_pkg::reg_rsp_t                       in_rsp_o,
  output bus_pkg::reg_req_t [`TIMER_IDX:0]        out_req_o,
  input  wire bus_pkg::reg_rsp_t [`TIMER_IDX:0]   out_rsp_i
);

  import periph_pkg::*;

  periph_idx_t idx;

  assign idx = in_req_i.addr[`PERIPH_IDX_LSB +: $bits(periph_idx_t)];

  always_comb begin
    // Unmapped unless a port below matches
    in_rsp_o.rdata = `REG_ERR_DATA;
    in_rsp_o.error = 1'b1;
    for (int i = 0; i <= `TIMER_IDX; i++) begin
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = in_req_i.valid && (idx == periph_idx_t'(i));
      if (idx == periph_idx_t'(i)) begin
        in_rsp_o = out_rsp_i[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/plic_lite.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Level gateways, lowest ID wins, no priorities or threshold.
// NumSrc from 12 to 32, source 0 is expected tied low.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module plic_lite #(
  parameter int unsigned NumSrc = 32
) (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire bus_pkg::reg_req_t  reg_req_i,
  output bus_pkg::reg_rsp_t       reg_rsp_o,
  input  wire logic [NumSrc-1:0]  intr_src_i,
  output logic                    irq_o,
  output logic                    msip_o
);

  import bus_pkg::*;
  import periph_pkg::*;

  logic [NumSrc-1:0]         pending_q;
  logic [NumSrc-1:0]         enable_q;
  logic [NumSrc-1:0]         in_service_q;
  logic                      msip_q;
  logic [`PERIPH_IDX_LSB-1:0] ofs;
  logic                      wr;
  logic                      claim_rd;
  irq_id_t                   claim_id;
  irq_id_t                   complete_id;
  logic [NumSrc-1:0]         claim_mask;
  logic [NumSrc-1:0]         complete_mask;
  data_t                     enable_wr;

  assign ofs         = reg_req_i.addr[`PERIPH_IDX_LSB-1:0];
  assign wr          = reg_req_i.valid && reg_req_i.write;
  assign claim_rd    = reg_req_i.valid && !reg_req_i.write && (ofs == `PLIC_CLAIM_OFS);
  assign complete_id = irq_id_t'(reg_req_i.wdata);

  // Lowest enabled pending source, 0 when none
  always_comb begin
    claim_id = '0;
    for (int i = NumSrc - 1; i > 0; i--) begin
      if (pending_q[i] && enable_q[i]) begin
        claim_id = irq_id_t'(i);
      end
    end
  end

  assign claim_mask    = (claim_rd && claim_id != '0) ?
                         ({{(NumSrc-1){1'b0}}, 1'b1} << claim_id) : '0;
  assign complete_mask = (wr && ofs == `PLIC_CLAIM_OFS) ?
                         ({{(NumSrc-1){1'b0}}, 1'b1} << complete_id) : '0;
  assign enable_wr     = masked_write(data_t'(enable_q), reg_req_i.wdata, reg_req_i.wstrb);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q    <= '0;
      enable_q     <= '0;
      in_service_q <= '0;
      msip_q       <= 1'b0;
    end else begin
      // Gateway blocks a source while it is pending or in service
      pending_q    <= (pending_q | (intr_src_i & ~in_service_q)) & ~claim_mask;
      in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
      if (wr && ofs == `PLIC_ENABLE_OFS) begin
        enable_q <= enable_wr[NumSrc-1:0];
      end
      if (wr && ofs == `PLIC_MSIP_OFS && reg_req_i.wstrb[0]) begin
        msip_q <= reg_req_i.wdata[0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (ofs)
      `PLIC_PENDING_OFS: reg_rsp_o.rdata = data_t'(pending_q);
      `PLIC_ENABLE_OFS:  reg_rsp_o.rdata = data_t'(enable_q);
      `PLIC_CLAIM_OFS:   reg_rsp_o.rdata = data_t'(claim_id);
      `PLIC_MSIP_OFS:    reg_rsp_o.rdata = data_t'(msip_q);
      default:           reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o  = |(pending_q & enable_q);
  assign msip_o = msip_q;

endmodule

`default_nettype wire

//--- rtl/gpio.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Inputs pass a two-flop synchronizer. Status bits latch rising edges
// and are cleared by writing 1.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module gpio (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  input  wire bus_pkg::reg_req_t   reg_req_i,
  output bus_pkg::reg_rsp_t        reg_rsp_o,
  input  wire periph_pkg::gpio_t   gpio_i,
  output periph_pkg::gpio_t        gpio_o,
  output periph_pkg::gpio_t        gpio_en_o,
  output periph_pkg::gpio_t        intr_o
);

  import bus_pkg::*;
  import periph_pkg::*;

  gpio_t                      sync_q;
  gpio_t                      in_q;
  gpio_t                      in_prev_q;
  gpio_t                      out_q;
  gpio_t                      oe_q;
  gpio_t                      ie_q;
  gpio_t                      status_q;
  gpio_t                      rise;
  gpio_t                      w1c;
  logic [`PERIPH_IDX_LSB-1:0] ofs;
  logic                       wr;

  assign ofs  = reg_req_i.addr[`PERIPH_IDX_LSB-1:0];
  assign wr   = reg_req_i.valid && reg_req_i.write;
  assign rise = in_q & ~in_prev_q;
  assign w1c  = (wr && ofs == `GPIO_STATUS_OFS) ?
                gpio_t'(reg_req_i.wdata & strb_mask(reg_req_i.wstrb)) : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q    <= '0;
      in_q      <= '0;
      in_prev_q <= '0;
      out_q     <= '0;
      oe_q      <= '0;
      ie_q      <= '0;
      status_q  <= '0;
    end else begin
      sync_q    <= gpio_i;
      in_q      <= sync_q;
      in_prev_q <= in_q;
      // A new edge wins over a clear in the same cycle
      status_q  <= (status_q & ~w1c) | rise;
      if (wr && ofs == `GPIO_OUT_OFS) begin
        out_q <= gpio_t'(masked_write(data_t'(out_q), reg_req_i.wdata, reg_req_i.wstrb));
      end
      if (wr && ofs == `GPIO_OE_OFS) begin
        oe_q <= gpio_t'(masked_write(data_t'(oe_q), reg_req_i.wdata, reg_req_i.wstrb));
      end
      if (wr && ofs == `GPIO_INTR_EN_OFS) begin
        ie_q <= gpio_t'(masked_write(data_t'(ie_q), reg_req_i.wdata, reg_req_i.wstrb));
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (ofs)
      `GPIO_IN_OFS:      reg_rsp_o.rdata = data_t'(in_q);
      `GPIO_OUT_OFS:     reg_rsp_o.rdata = data_t'(out_q);
      `GPIO_OE_OFS:      reg_rsp_o.rdata = data_t'(oe_q);
      `GPIO_INTR_EN_OFS: reg_rsp_o.rdata = data_t'(ie_q);
      `GPIO_STATUS_OFS:  reg_rsp_o.rdata = data_t'(status_q);
      default:           reg_rsp_o.rdata = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = oe_q;
  assign intr_o    = status_q & ie_q;

endmodule

`default_nettype wire

//--- rtl/rv_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32-bit mtime, no wrap handling. Compare interrupts are levels that stay
// high while mtime is at or above the compare value.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module rv_timer (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire bus_pkg::reg_req_t  reg_req_i,
  output bus_pkg::reg_rsp_t       reg_rsp_o,
  output logic [1:0]              intr_o
);

  import bus_pkg::*;
  import periph_pkg::*;

  mtime_t                     mtime_q;
  mtime_t                     prescale_q;
  mtime_t                     presc_cnt_q;
  mtime_t                     cmp0_q;
  mtime_t                     cmp1_q;
  logic                       enable_q;
  logic                       tick;
  logic [`PERIPH_IDX_LSB-1:0] ofs;
  logic                       wr;

  assign ofs  = reg_req_i.addr[`PERIPH_IDX_LSB-1:0];
  assign wr   = reg_req_i.valid && reg_req_i.write;
  // Compare with >= so a smaller prescale written mid-count still ticks
  assign tick = enable_q && (presc_cnt_q >= prescale_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mtime_q     <= '0;
      prescale_q  <= '0;
      presc_cnt_q <= '0;
      enable_q    <= 1'b0;
      cmp0_q      <= '1;
      cmp1_q      <= '1;
    end else begin
      if (tick) begin
        presc_cnt_q <= '0;
        mtime_q     <= mtime_q + 1'b1;
      end else if (enable_q) begin
        presc_cnt_q <= presc_cnt_q + 1'b1;
      end
      // Software writes override the increment
      if (wr) begin
        case (ofs)
          `TIMER_MTIME_OFS: mtime_q <= masked_write(mtime_q, reg_req_i.wdata, reg_req_i.wstrb);
          `TIMER_PRESC_OFS: prescale_q <= masked_write(prescale_q, reg_req_i.wdata,
                                                       reg_req_i.wstrb);
          `TIMER_CTRL_OFS: begin
            if (reg_req_i.wstrb[0]) begin
              enable_q <= reg_req_i.wdata[0];
            end
          end
          `TIMER_CMP0_OFS:  cmp0_q <= masked_write(cmp0_q, reg_req_i.wdata, reg_req_i.wstrb);
          `TIMER_CMP1_OFS:  cmp1_q <= masked_write(cmp1_q, reg_req_i.wdata, reg_req_i.wstrb);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    case (ofs)
      `TIMER_MTIME_OFS: reg_rsp_o.rdata = mtime_q;
      `TIMER_PRESC_OFS: reg_rsp_o.rdata = prescale_q;
      `TIMER_CTRL_OFS:  reg_rsp_o.rdata = data_t'(enable_q);
      `TIMER_CMP0_OFS:  reg_rsp_o.rdata = cmp0_q;
      `TIMER_CMP1_OFS:  reg_rsp_o.rdata = cmp1_q;
      default:          reg_rsp_o.rdata = '0;
    endcase
  end

  assign intr_o[0] = (mtime_q >= cmp0_q);
  assign intr_o[1] = (mtime_q >= cmp1_q);

endmodule

`default_nettype wire

//--- rtl/peripheral_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NEXT_INT external interrupt lines, 1 to 21. External sources start at
// ID 11, after the GPIO pins and both timer compares.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module peripheral_subsystem #(
  parameter int unsigned NEXT_INT = 4
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_n_i,

  input  wire bus_pkg::obi_req_t    slave_req_i,
  output bus_pkg::obi_resp_t        slave_resp_o,

  input  wire logic [NEXT_INT-1:0]  intr_vector_ext_i,
  output logic                      irq_plic_o,
  output logic                      msip_o,

  input  wire periph_pkg::gpio_t    cio_gpio_i,
  output periph_pkg::gpio_t         cio_gpio_o,
  output periph_pkg::gpio_t         cio_gpio_en_o,

  output logic                      rv_timer_2_intr_o,
  output logic                      rv_timer_3_intr_o
);

  import bus_pkg::*;
  import periph_pkg::*;

  localparam int unsigned NumSrc = `PLIC_USED_NINT + NEXT_INT;

  reg_req_t                  periph_req;
  reg_rsp_t                  periph_rsp;
  reg_req_t [`TIMER_IDX:0]   slv_req;
  reg_rsp_t [`TIMER_IDX:0]   slv_rsp;
  gpio_t                     gpio_intr;
  logic [1:0]                timer_intr;
  logic [NumSrc-1:0]         intr_vector;

  // ID 0 means no interrupt
  assign intr_vector[0]                               = 1'b0;
  assign intr_vector[`PLIC_GPIO_SRC +: `GPIO_WIDTH]   = gpio_intr;
  assign intr_vector[`PLIC_TIMER_SRC +: 2]            = timer_intr;
  assign intr_vector[`PLIC_USED_NINT +: NEXT_INT]     = intr_vector_ext_i;

  assign rv_timer_2_intr_o = timer_intr[0];
  assign rv_timer_3_intr_o = timer_intr[1];

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_n_i,
    .obi_req_i  (slave_req_i),
    .obi_resp_o (slave_resp_o),
    .reg_req_o  (periph_req),
    .reg_rsp_i  (periph_rsp)
  );

  reg_demux reg_demux_i (
    .in_req_i  (periph_req),
    .in_rsp_o  (periph_rsp),
    .out_req_o (slv_req),
    .out_rsp_i (slv_rsp)
  );

  plic_lite #(
    .NumSrc (NumSrc)
  ) plic_lite_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i  (slv_req[`PLIC_IDX]),
    .reg_rsp_o  (slv_rsp[`PLIC_IDX]),
    .intr_src_i (intr_vector),
    .irq_o      (irq_plic_o),
    .msip_o
  );

  gpio gpio_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (slv_req[`GPIO_IDX]),
    .reg_rsp_o (slv_rsp[`GPIO_IDX]),
    .gpio_i    (cio_gpio_i),
    .gpio_o    (cio_gpio_o),
    .gpio_en_o (cio_gpio_en_o),
    .intr_o    (gpio_intr)
  );

  rv_timer rv_timer_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (slv_req[`TIMER_IDX]),
    .reg_rsp_o (slv_rsp[`TIMER_IDX]),
    .intr_o    (timer_intr)
  );

endmodule

`default_nettype wire

//--- verification/tb_peripheral_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench, NEXT_INT fixed at 4. Stops at the first error,
// every wait on the DUT is bounded by a cycle or poll count.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_consts.svh"

module tb_peripheral_subsystem;

  import bus_pkg::*;
  import periph_pkg::*;

  localparam int unsigned NEXT_INT    = 4;
  localparam int unsigned NUM_SRC     = `PLIC_USED_NINT + NEXT_INT;
  localparam int unsigned RSP_TIMEOUT = 8;
  localparam int unsigned POLL_LIMIT  = 200;
  localparam data_t       GPIO_MASK   = data_t'({`GPIO_WIDTH{1'b1}});

  logic                clk;
  logic                rst_n;
  obi_req_t            req;
  obi_resp_t           resp;
  logic [NEXT_INT-1:0] ext_irq;
  logic                irq_plic;
  logic                msip;
  gpio_t               gpio_in;
  gpio_t               gpio_out;
  gpio_t               gpio_en;
  logic                timer_irq0;
  logic                timer_irq1;

  // GPIO out, GPIO enable, cmp0, cmp1
  addr_t rw_addr [4];
  data_t rw_mask [4];
  data_t rw_shadow [4];
  string rw_name [4];

  peripheral_subsystem #(
    .NEXT_INT (NEXT_INT)
  ) dut0 (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .slave_req_i       (req),
    .slave_resp_o      (resp),
    .intr_vector_ext_i (ext_irq),
    .irq_plic_o        (irq_plic),
    .msip_o            (msip),
    .cio_gpio_i        (gpio_in),
    .cio_gpio_o        (gpio_out),
    .cio_gpio_en_o     (gpio_en),
    .rv_timer_2_intr_o (timer_irq0),
    .rv_timer_3_intr_o (timer_irq1)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic addr_t reg_addr(input periph_idx_t idx, input logic [11:0] ofs);
    return `PERIPH_BASE + (addr_t'(idx) << `PERIPH_IDX_LSB) + addr_t'(ofs);
  endfunction

  // Only bytes with their enable set take the new value
  function automatic data_t exp_reg(input data_t old_val, input data_t wdata, input strb_t be);
    data_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic irq_id_t exp_claim(input data_t pend, input data_t en);
    irq_id_t id;
    id = '0;
    for (int i = 1; i < NUM_SRC; i++) begin
      if (id == '0 && pend[i] && en[i]) begin
        id = irq_id_t'(i);
      end
    end
    return id;
  endfunction

  function automatic logic timer_level(input int unsigned which);
    return (which == 0) ? timer_irq0 : timer_irq1;
  endfunction

  task automatic abort_test();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
      abort_test();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp, act);
      abort_test();
    end
  endtask

  task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s expected 0x%02h actual 0x%02h", $time, name, exp, act);
      abort_test();
    end
  endtask

  task automatic check_id(input string name, input irq_id_t exp, input irq_id_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
      abort_test();
    end
  endtask

  // One OBI access, returns at the falling edge where rvalid is seen
  task automatic obi_transfer(input logic we, input addr_t addr, input strb_t be,
                              input data_t wdata, output data_t rdata, output logic err);
    int unsigned waited;
    @(negedge clk);
    check_bit("slave_resp_o.gnt", 1'b0, resp.gnt);
    check_bit("slave_resp_o.rvalid", 1'b0, resp.rvalid);
    req.req   = 1'b1;
    req.we    = we;
    req.be    = be;
    req.addr  = addr;
    req.wdata = wdata;
    @(negedge clk);
    check_bit("slave_resp_o.gnt", 1'b1, resp.gnt);
    req    = '0;
    waited = 0;
    while (resp.rvalid !== 1'b1) begin
      if (waited == RSP_TIMEOUT) begin
        $display("%0t ns no OBI response for the access at 0x%08h", $time, addr);
        abort_test();
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    rdata = resp.rdata;
    err   = resp.err;
  endtask

  task automatic obi_write(input addr_t addr, input strb_t be, input data_t wdata,
                           input logic exp_err);
    data_t rdata;
    logic  err;
    obi_transfer(1'b1, addr, be, wdata, rdata, err);
    check_bit("slave_resp_o.err", exp_err, err);
    check_data("slave_resp_o.rdata", '0, rdata);
  endtask

  task automatic obi_read(input addr_t addr, input logic exp_err, output data_t rdata);
    logic err;
    obi_transfer(1'b0, addr, 4'hF, '0, rdata, err);
    check_bit("slave_resp_o.err", exp_err, err);
  endtask

  task automatic wait_gpio_status(input int unsigned pin);
    data_t       rd;
    int unsigned polls;
    polls = 0;
    obi_read(reg_addr(`GPIO_IDX, `GPIO_STATUS_OFS), 1'b0, rd);
    while (rd[pin] !== 1'b1) begin
      if (polls == POLL_LIMIT) begin
        $display("%0t ns GPIO status bit %0d never set", $time, pin);
        abort_test();
      end else begin
        obi_read(reg_addr(`GPIO_IDX, `GPIO_STATUS_OFS), 1'b0, rd);
        polls++;
      end
    end
  endtask

  task automatic wait_plic_irq();
    int unsigned cycles;
    cycles = 0;
    while (irq_plic !== 1'b1) begin
      if (cycles == POLL_LIMIT) begin
        $display("%0t ns irq_plic_o never went high", $time);
        abort_test();
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  // mtime must never step back while the compare is pending
  task automatic poll_mtime(input int unsigned which, input data_t cmp, inout data_t prev);
    data_t       rd;
    int unsigned polls;
    polls = 0;
    while (timer_level(which) !== 1'b1) begin
      if (polls == POLL_LIMIT) begin
        $display("%0t ns timer compare %0d interrupt never went high", $time, which);
        abort_test();
      end else begin
        obi_read(reg_addr(`TIMER_IDX, `TIMER_MTIME_OFS), 1'b0, rd);
        check_bit("mtime not decreasing", 1'b1, rd >= prev);
        prev = rd;
        polls++;
      end
    end
    obi_read(reg_addr(`TIMER_IDX, `TIMER_MTIME_OFS), 1'b0, rd);
    check_bit("mtime not decreasing", 1'b1, rd >= prev);
    check_bit("mtime at or above compare", 1'b1, rd >= cmp);
    prev = rd;
  endtask

  task automatic test_reg_rw();
    data_t       wdata;
    data_t       rd;
    strb_t       be;
    int unsigned sel;
    rw_addr[0] = reg_addr(`GPIO_IDX, `GPIO_OUT_OFS);
    rw_addr[1] = reg_addr(`GPIO_IDX, `GPIO_OE_OFS);
    rw_addr[2] = reg_addr(`TIMER_IDX, `TIMER_CMP0_OFS);
    rw_addr[3] = reg_addr(`TIMER_IDX, `TIMER_CMP1_OFS);
    rw_name    = '{"gpio out", "gpio output enable", "timer cmp0", "timer cmp1"};
    rw_mask    = '{GPIO_MASK, GPIO_MASK, '1, '1};
    rw_shadow  = '{'0, '0, '1, '1};
    for (int n = 0; n < 32; n++) begin
      sel   = $urandom % 4;
      wdata = $urandom;
      be    = strb_t'($urandom);
      rw_shadow[sel] = exp_reg(rw_shadow[sel], wdata, be) & rw_mask[sel];
      obi_write(rw_addr[sel], be, wdata, 1'b0);
      obi_read(rw_addr[sel], 1'b0, rd);
      check_data(rw_name[sel], rw_shadow[sel], rd);
      check_gpio("cio_gpio_o", gpio_t'(rw_shadow[0]), gpio_out);
      check_gpio("cio_gpio_en_o", gpio_t'(rw_shadow[1]), gpio_en);
    end
  endtask

  task automatic test_unmapped();
    data_t rd;
    obi_read(reg_addr(2'd3, `GPIO_OUT_OFS), 1'b1, rd);
    check_data("unmapped rdata", `REG_ERR_DATA, rd);
    // Offsets that alias live registers in the mapped windows
    obi_write(reg_addr(2'd3, `GPIO_OUT_OFS), 4'hF, ~rw_shadow[0], 1'b1);
    obi_write(reg_addr(2'd3, `TIMER_CMP0_OFS), 4'hF, ~rw_shadow[2], 1'b1);
    for (int i = 0; i < 4; i++) begin
      obi_read(rw_addr[i], 1'b0, rd);
      check_data(rw_name[i], rw_shadow[i], rd);
    end
    check_gpio("cio_gpio_o", gpio_t'(rw_shadow[0]), gpio_out);
  endtask

  task automatic test_gpio_irq();
    int unsigned pin;
    irq_id_t     id;
    data_t       en;
    data_t       rd;
    pin = $urandom % `GPIO_WIDTH;
    id  = irq_id_t'(`PLIC_GPIO_SRC + pin);
    en  = data_t'(1) << id;
    obi_write(reg_addr(`PLIC_IDX, `PLIC_ENABLE_OFS), 4'hF, en, 1'b0);
    obi_write(reg_addr(`GPIO_IDX, `GPIO_INTR_EN_OFS), 4'hF, data_t'(1) << pin, 1'b0);
    @(negedge clk);
    gpio_in[pin] = 1'b1;
    wait_gpio_status(pin);
    wait_plic_irq();
    obi_read(reg_addr(`PLIC_IDX, `PLIC_CLAIM_OFS), 1'b0, rd);
    check_id("claim ID", exp_claim(en, en), irq_id_t'(rd));
    check_bit("irq_plic_o", 1'b0, irq_plic);
    obi_write(reg_addr(`GPIO_IDX, `GPIO_STATUS_OFS), 4'hF, data_t'(1) << pin, 1'b0);
    obi_write(reg_addr(`PLIC_IDX, `PLIC_CLAIM_OFS), 4'hF, data_t'(id), 1'b0);
    obi_read(reg_addr(`PLIC_IDX, `PLIC_PENDING_OFS), 1'b0, rd);
    check_bit("pending bit of the GPIO source", 1'b0, rd[id]);
    check_bit("irq_plic_o", 1'b0, irq_plic);
    gpio_in[pin] = 1'b0;
  endtask

  task automatic test_multi_claim();
    int unsigned         pin;
    logic [NEXT_INT-1:0] ext;
    data_t               src_mask;
    data_t               en;
    data_t               pend;
    data_t               claimed;
    data_t               rd;
    irq_id_t             id;
    pin      = $urandom % `GPIO_WIDTH;
    ext      = NEXT_INT'($urandom);
    src_mask = (data_t'(1) << (`PLIC_GPIO_SRC + pin)) |
               (data_t'({NEXT_INT{1'b1}}) << `PLIC_USED_NINT);
    en       = $urandom & src_mask;
    pend     = (data_t'(ext) << `PLIC_USED_NINT) | (data_t'(1) << (`PLIC_GPIO_SRC + pin));
    claimed  = '0;
    obi_write(reg_addr(`PLIC_IDX, `PLIC_ENABLE_OFS), 4'hF, en, 1'b0);
    obi_write(reg_addr(`GPIO_IDX, `GPIO_INTR_EN_OFS), 4'hF, data_t'(1) << pin, 1'b0);
    @(negedge clk);
    ext_irq      = ext;
    gpio_in[pin] = 1'b1;
    wait_gpio_status(pin);
    obi_read(reg_addr(`PLIC_IDX, `PLIC_PENDING_OFS), 1'b0, rd);
    check_data("pending", pend, rd & src_mask);
    check_bit("irq_plic_o", exp_claim(pend, en) != '0, irq_plic);
    while (exp_claim(pend, en) != '0) begin
      id = exp_claim(pend, en);
      obi_read(reg_addr(`PLIC_IDX, `PLIC_CLAIM_OFS), 1'b0, rd);
      check_id("claim ID", id, irq_id_t'(rd));
      pend[id]    = 1'b0;
      claimed[id] = 1'b1;
    end
    obi_read(reg_addr(`PLIC_IDX, `PLIC_CLAIM_OFS), 1'b0, rd);
    check_id("final claim ID", '0, irq_id_t'(rd));
    check_bit("irq_plic_o", 1'b0, irq_plic);
    // Drop every source before completing
    @(negedge clk);
    ext_irq = '0;
    gpio_in = '0;
    obi_write(reg_addr(`GPIO_IDX, `GPIO_STATUS_OFS), 4'hF, GPIO_MASK, 1'b0);
    for (int i = 1; i < NUM_SRC; i++) begin
      if (claimed[i]) begin
        obi_write(reg_addr(`PLIC_IDX, `PLIC_CLAIM_OFS), 4'hF, data_t'(i), 1'b0);
      end
    end
    obi_write(reg_addr(`PLIC_IDX, `PLIC_ENABLE_OFS), 4'hF, '0, 1'b0);
  endtask

  task automatic test_timer();
    data_t presc;
    data_t cmp0;
    data_t cmp1;
    data_t prev;
    presc = $urandom % 4;
    cmp0  = 8 + $urandom % 16;
    cmp1  = cmp0 + 4 + $urandom % 16;
    obi_write(reg_addr(`TIMER_IDX, `TIMER_PRESC_OFS), 4'hF, presc, 1'b0);
    obi_write(reg_addr(`TIMER_IDX, `TIMER_CMP0_OFS), 4'hF, cmp0, 1'b0);
    obi_write(reg_addr(`TIMER_IDX, `TIMER_CMP1_OFS), 4'hF, cmp1, 1'b0);
    check_bit("rv_timer_2_intr_o", 1'b0, timer_irq0);
    check_bit("rv_timer_3_intr_o", 1'b0, timer_irq1);
    obi_write(reg_addr(`TIMER_IDX, `TIMER_CTRL_OFS), 4'h1, 32'h1, 1'b0);
    prev = '0;
    poll_mtime(0, cmp0, prev);
    poll_mtime(1, cmp1, prev);
    check_bit("rv_timer_2_intr_o", 1'b1, timer_irq0);
    obi_write(reg_addr(`TIMER_IDX, `TIMER_CTRL_OFS), 4'h1, 32'h0, 1'b0);
  endtask

  task automatic test_msip();
    data_t rd;
    obi_write(reg_addr(`PLIC_IDX, `PLIC_MSIP_OFS), 4'h1, 32'h1, 1'b0);
    check_bit("msip_o", 1'b1, msip);
    obi_read(reg_addr(`PLIC_IDX, `PLIC_MSIP_OFS), 1'b0, rd);
    check_data("msip register", 32'h1, rd);
    obi_write(reg_addr(`PLIC_IDX, `PLIC_MSIP_OFS), 4'h1, 32'h0, 1'b0);
    check_bit("msip_o", 1'b0, msip);
  endtask

  initial begin
    void'($urandom(87));
    rst_n   = 1'b0;
    req     = '0;
    ext_irq = '0;
    gpio_in = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit("irq_plic_o", 1'b0, irq_plic);
    check_bit("msip_o", 1'b0, msip);
    check_bit("rv_timer_2_intr_o", 1'b0, timer_irq0);
    check_bit("rv_timer_3_intr_o", 1'b0, timer_irq1);
    check_bit("slave_resp_o.rvalid", 1'b0, resp.rvalid);
    check_gpio("cio_gpio_o", '0, gpio_out);
    check_gpio("cio_gpio_en_o", '0, gpio_en);
    test_reg_rw();
    test_unmapped();
    test_gpio_irq();
    test_multi_claim();
    test_timer();
    test_msip();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
rtl/bus_pkg.sv
rtl/periph_pkg.sv
rtl/obi_to_reg.sv
rtl/reg_demux.sv
rtl/plic_lite.sv
rtl/gpio.sv
rtl/rv_timer.sv
rtl/peripheral_subsystem.sv
verification/tb_peripheral_subsystem.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_peripheral_subsystem

if ! verilator --binary --timing -Wno-fatal --top-module "$TOP" \
    -f filelist.f -Mdir obj_dir -o sim_"$TOP"; then
  echo "Verilator build failed" >&2
  exit 1
fi

if ! ./obj_dir/sim_"$TOP" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status" >&2
  exit 1
fi

cat "$LOG"

if grep -qx "test passed" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG" >&2
  exit 1
fi
